/* rtl/cachePkg.sv */
// Geometry assumes 32-bit words, 4-word lines, a 1024-word window and NumSets from 4 to 64
`default_nettype none

package cachePkg;

  ////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////
  localparam int WordBits        = 32;
  localparam int LineWords       = 4;
  localparam int LineBits        = WordBits * LineWords;  // 128
  localparam int WordOffsetBits  = 2;
  localparam int MemWordAddrBits = 10;                     // 1024 words behind the cache
  localparam int LineAddrBits    = MemWordAddrBits - WordOffsetBits; // 256 lines
  localparam int MaxTagBits      = LineAddrBits - 2;       // Widest tag, at 4 sets
  localparam int CtrlWindowBit   = 15;                     // PADDR bit for the control window
  localparam int MemLatency      = 4;                      // Backing memory cycles per access

  typedef enum logic [1:0] {opNone, opRead, opWrite, opFlush} cacheOp_t;

  typedef enum logic [2:0] {
    sIdle, sLookup, sRespond, sWriteBack, sRefill, sFlushScan, sFlushWrite, sDone
  } ctrlState_t;

  // Per-way command. The controller puts the flush way index in flushWay,
  // the top level turns it into a one-hot bit per way
  typedef struct packed {
    logic                 victimWay;     // This way is the LRU victim
    logic                 flushWay;      // This way is the flush target
    logic                 selVictim;     // Select victim instead of hit
    logic                 flushCache;    // Flush in progress
    logic                 setValid;      // Whole-line refill
    logic                 setDirty;      // Word write
    logic                 clearDirty;
    logic                 invalidateAll;
    logic [LineWords-1:0] wordMask;      // Word enables
  } wayCmd_t;

  typedef struct packed {
    logic                  hit;
    logic                  valid;
    logic                  dirty;        // Only for the victim or flush way
    logic [MaxTagBits-1:0] tag;          // Zero unless this way is selected
  } wayStatus_t;

  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [LineAddrBits-1:0] lineAddr;
    logic [LineBits-1:0]     data;
  } memReq_t;

  typedef struct packed {
    logic                done;           // One-cycle pulse
    logic [LineBits-1:0] data;
  } memRsp_t;

endpackage

`default_nettype wire

/* rtl/cacheWay.sv */
// One cache way in registers, with reads one cycle after setIndex and writes visible in that read
`timescale 1ns/1ps
`default_nettype none

module cacheWay import cachePkg::*; #(
  parameter int NumSets = 16,
  localparam int IndexBits = $clog2(NumSets),
  localparam int TagBits = LineAddrBits - IndexBits
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cacheEn,     // Arrays update and read only when set
  input  logic [IndexBits-1:0] setIndex,
  input  logic [TagBits-1:0]   lookupTag,
  input  wayCmd_t              cmd,
  input  logic [LineBits-1:0]  writeLine,
  output logic [LineBits-1:0]  readLine,    // Zero unless this way is selected
  output wayStatus_t           status
);

  logic [TagBits-1:0]                    tagMem [NumSets];
  logic [LineWords-1:0][WordBits-1:0]    dataMem [NumSets];
  logic [NumSets-1:0]                    validBits;
  logic [NumSets-1:0]                    dirtyBits;

  logic [TagBits-1:0]                    readTag;
  logic [LineWords-1:0][WordBits-1:0]    readData;
  logic [LineWords-1:0][WordBits-1:0]    wrWords;
  logic                                  validQ;
  logic                                  dirtyQ;
  logic                                  hit;
  logic                                  selWay;
  logic [LineWords-1:0]                  wordWe;
  logic [TagBits-1:0]                    tagOut;

  ////////////////////////////////////////
  // Way selection and enables
  ////////////////////////////////////////
  assign hit = validQ & (readTag == lookupTag);
  // Flush target wins, then victim, then hit
  assign selWay = cmd.flushCache ? cmd.flushWay : (cmd.selVictim ? cmd.victimWay : hit);

  assign wrWords = writeLine;
  always_comb begin
    for (int w = 0; w < LineWords; w++) begin
      wordWe[w] = selWay & (cmd.setValid | (cmd.setDirty & cmd.wordMask[w]));
    end
  end

  ////////////////////////////////////////
  // Tag and data arrays
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (cacheEn) begin
      if (selWay & cmd.setValid) begin // Refill brings in a new tag
        tagMem[setIndex] <= lookupTag;
        readTag          <= lookupTag;
      end else begin
        readTag <= tagMem[setIndex];
      end
      for (int w = 0; w < LineWords; w++) begin
        if (wordWe[w]) begin
          dataMem[setIndex][w] <= wrWords[w];
          readData[w]          <= wrWords[w]; // Write-first so retry sees new data
        end else begin
          readData[w] <= dataMem[setIndex][w];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Valid and dirty bits
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      validQ    <= 1'b0;
    end else if (cacheEn) begin
      if (cmd.invalidateAll) begin
        validBits <= '0;
        validQ    <= 1'b0;
      end else if (selWay & cmd.setValid) begin
        validBits[setIndex] <= 1'b1;
        validQ              <= 1'b1;
      end else begin
        validQ <= validBits[setIndex];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dirtyBits <= '0;
      dirtyQ    <= 1'b0;
    end else if (cacheEn) begin
      if (selWay & cmd.setDirty) begin
        dirtyBits[setIndex] <= 1'b1;
        dirtyQ              <= 1'b1;
      end else if (selWay & cmd.clearDirty) begin // Refill or flush writeback
        dirtyBits[setIndex] <= 1'b0;
        dirtyQ              <= 1'b0;
      end else begin
        dirtyQ <= dirtyBits[setIndex];
      end
    end
  end

  // AND half of the AND-OR mux
  assign tagOut   = selWay ? readTag : '0;
  assign readLine = selWay ? readData : '0;

  assign status = '{
    hit:   hit,
    valid: validQ,
    dirty: validQ & dirtyQ & (cmd.flushCache ? cmd.flushWay : cmd.victimWay),
    tag:   MaxTagBits'(tagOut)
  };

endmodule

`default_nettype wire

/* rtl/wayCombine.sv */
// Two-way combiner and LRU store, which picks an invalid way first and otherwise the LRU way
`timescale 1ns/1ps
`default_nettype none

module wayCombine import cachePkg::*; #(
  parameter int NumSets = 16,
  localparam int IndexBits = $clog2(NumSets),
  localparam int TagBits = LineAddrBits - IndexBits
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [IndexBits-1:0] setIndex,
  input  wayStatus_t           statusA,
  input  wayStatus_t           statusB,
  input  logic [LineBits-1:0]  lineA,
  input  logic [LineBits-1:0]  lineB,
  input  logic                 touch,       // Hit used this set
  output logic                 anyHit,
  output logic [LineBits-1:0]  line,
  output logic                 victimDirty,
  output logic [TagBits-1:0]   victimTag,
  output logic [1:0]           victimSel    // Bit 0 is way A
);

  logic [NumSets-1:0]    lruBits;           // Set means way B is least recent
  logic [MaxTagBits-1:0] tagOr;

  // OR half of the AND-OR mux, ways already masked
  assign anyHit      = statusA.hit | statusB.hit;
  assign line        = lineA | lineB;
  assign victimDirty = statusA.dirty | statusB.dirty;
  assign tagOr       = statusA.tag | statusB.tag;
  assign victimTag   = tagOr[TagBits-1:0];

  always_comb begin
    if (!statusA.valid) begin
      victimSel = 2'b01;
    end else if (!statusB.valid) begin
      victimSel = 2'b10;
    end else begin
      victimSel = lruBits[setIndex] ? 2'b10 : 2'b01;
    end
  end

  // Point LRU at the way not just used
  always_ff @(posedge clk) begin
    if (reset) begin
      lruBits <= '0;
    end else if (touch) begin
      lruBits[setIndex] <= statusA.hit;
    end
  end

endmodule

`default_nettype wire

/* rtl/cacheCtrl.sv */
// APB controller for one transfer at a time, where PADDR must stay stable until PREADY
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl import cachePkg::*; #(
  parameter int NumSets = 16,
  localparam int IndexBits = $clog2(NumSets),
  localparam int TagBits = LineAddrBits - IndexBits
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 PSEL,
  input  logic                 PENABLE,
  input  logic                 PWRITE,
  input  logic [15:0]          PADDR,
  input  logic [WordBits-1:0]  PWDATA,
  output logic [WordBits-1:0]  PRDATA,
  output logic                 PREADY,
  output logic                 PSLVERR,
  output wayCmd_t              cmd,
  output logic [IndexBits-1:0] setIndex,
  output logic [TagBits-1:0]   lookupTag,
  output logic [LineBits-1:0]  writeLine,
  output logic                 cacheEn,
  input  logic                 anyHit,
  input  logic [LineBits-1:0]  line,
  input  logic                 victimDirty,
  input  logic [TagBits-1:0]   victimTag,
  output logic                 touch,
  output memReq_t              memReq,
  input  memRsp_t              memRsp
);

  localparam int IndexLsb = WordOffsetBits + 2;
  localparam int TagLsb   = IndexLsb + IndexBits;

  ctrlState_t                state;
  cacheOp_t                  curOp;
  logic [31:0]               hitCount;
  logic [31:0]               missCount;
  logic                      retried;     // Lookup after refill is not counted
  logic [IndexBits-1:0]      flushSet;
  logic                      flushWayIdx;
  logic                      flushRd;     // Arrays hold flushSet data
  logic [WordBits-1:0]       prdataQ;
  logic                      pslverrQ;
  logic                      access;
  logic                      flushing;
  logic [CtrlWindowBit-1:0]  ctrlOfs;
  logic [WordOffsetBits-1:0] wordOfs;

  assign access   = PSEL & PENABLE;
  assign ctrlOfs  = PADDR[CtrlWindowBit-1:0];
  assign wordOfs  = PADDR[IndexLsb-1:2];
  assign flushing = (state == sFlushScan) | (state == sFlushWrite);

  assign setIndex  = flushing ? flushSet : PADDR[TagLsb-1:IndexLsb];
  assign lookupTag = PADDR[MemWordAddrBits+1:TagLsb];
  assign cacheEn   = PSEL | (state != sIdle);
  assign touch     = (state == sLookup) & anyHit;
  assign writeLine = (state == sRefill) ? memRsp.data : {LineWords{PWDATA}};

  assign PREADY  = (state == sRespond);
  assign PRDATA  = prdataQ;
  assign PSLVERR = pslverrQ;

  ////////////////////////////////////////
  // Way command and memory request
  ////////////////////////////////////////
  always_comb begin
    cmd               = '0;
    cmd.victimWay     = 1'b0;                 // Filled in per way by the combiner
    cmd.flushWay      = flushWayIdx;
    cmd.selVictim     = (state == sWriteBack) | (state == sRefill);
    cmd.flushCache    = flushing;
    cmd.setValid      = (state == sRefill) & memRsp.done;
    cmd.setDirty      = (state == sLookup) & anyHit & (curOp == opWrite);
    cmd.clearDirty    = ((state == sRefill) | (state == sFlushWrite)) & memRsp.done;
    cmd.invalidateAll = (state == sDone);
    cmd.wordMask      = LineWords'(1) << wordOfs;
  end

  always_comb begin
    memReq.valid    = (state == sWriteBack) | (state == sRefill) | (state == sFlushWrite);
    memReq.write    = (state == sWriteBack) | (state == sFlushWrite);
    memReq.lineAddr = (state == sRefill) ? {lookupTag, setIndex} : {victimTag, setIndex};
    memReq.data     = line;                   // Victim or flush way line
  end

  ////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= sIdle;
      curOp       <= opNone;
      hitCount    <= '0;
      missCount   <= '0;
      retried     <= 1'b0;
      pslverrQ    <= 1'b0;
      flushSet    <= '0;
      flushWayIdx <= 1'b0;
      flushRd     <= 1'b0;
    end else begin
      case (state)
        sIdle: if (access) begin
          pslverrQ <= 1'b0;
          if (!PADDR[CtrlWindowBit]) begin
            curOp <= PWRITE ? opWrite : opRead;
            state <= sLookup;
          end else begin
            state   <= sRespond;
            prdataQ <= '0;
            if (!PWRITE && ctrlOfs == 0) begin
              prdataQ <= hitCount;
            end else if (!PWRITE && ctrlOfs == 4) begin
              prdataQ <= missCount;
            end else if (PWRITE && ctrlOfs == 8) begin
              if (PWDATA[0]) begin // Writing 0 is accepted and ignored
                curOp       <= opFlush;
                state       <= sFlushScan;
                flushSet    <= '0;
                flushWayIdx <= 1'b0;
                flushRd     <= 1'b0;
              end
            end else begin
              pslverrQ <= 1'b1;
            end
          end
        end
        sLookup: begin
          if (anyHit) begin
            if (!retried) hitCount <= hitCount + 1;
            prdataQ <= (curOp == opWrite) ? '0 : line[wordOfs*WordBits +: WordBits];
            state   <= sRespond;
          end else begin
            if (!retried) missCount <= missCount + 1;
            retried <= 1'b1;
            state   <= victimDirty ? sWriteBack : sRefill;
          end
        end
        sWriteBack: if (memRsp.done) state <= sRefill;
        sRefill:    if (memRsp.done) state <= sLookup;  // Retry now hits
        sRespond: begin
          state   <= sIdle;
          curOp   <= opNone;
          retried <= 1'b0;
        end
        sFlushScan: begin
          if (!flushRd) begin
            flushRd <= 1'b1;                    // Wait for the array read
          end else if (victimDirty) begin
            state <= sFlushWrite;
          end else if (!flushWayIdx) begin
            flushWayIdx <= 1'b1;
          end else if (flushSet == IndexBits'(NumSets - 1)) begin
            state <= sDone;
          end else begin
            flushSet    <= flushSet + 1'b1;
            flushWayIdx <= 1'b0;
            flushRd     <= 1'b0;
          end
        end
        sFlushWrite: if (memRsp.done) state <= sFlushScan; // Rescan sees it clean
        sDone: begin
          prdataQ <= '0;
          state   <= sRespond;
        end
        default: state <= sIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/backingMem.sv */
// Line-wide main memory without reset that accepts one request at a time, done after MemLatency
`timescale 1ns/1ps
`default_nettype none

module backingMem import cachePkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  memReq_t req,
  output memRsp_t rsp
);

  localparam int CntBits = $clog2(MemLatency);

  logic [LineBits-1:0] mem [1 << LineAddrBits];
  memReq_t             reqQ;
  logic                busy;
  logic [CntBits-1:0]  cnt;
  logic                doneQ;
  logic [LineBits-1:0] rdataQ;
  logic                accept;
  logic                expire;

  // Skip the done cycle so a held request is not taken twice
  assign accept = req.valid & ~busy & ~doneQ;
  assign expire = busy & (cnt == 0);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      doneQ <= 1'b0;
      cnt   <= '0;
    end else begin
      doneQ <= expire;
      if (accept) begin
        busy <= 1'b1;
        cnt  <= CntBits'(MemLatency - 1);
      end else if (expire) begin
        busy <= 1'b0;
      end else if (busy) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) reqQ <= req;
    if (expire) begin
      if (reqQ.write) mem[reqQ.lineAddr] <= reqQ.data;
      else            rdataQ <= mem[reqQ.lineAddr];
    end
  end

  assign rsp = '{done: doneQ, data: rdataQ};

endmodule

`default_nettype wire

/* rtl/apbCache.sv */
// Top of the APB cache, where NumSets must be a power of two from 4 to 64
`timescale 1ns/1ps
`default_nettype none

module apbCache import cachePkg::*; #(
  parameter int NumSets = 16,
  localparam int IndexBits = $clog2(NumSets),
  localparam int TagBits = LineAddrBits - IndexBits
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                PSEL,
  input  logic                PENABLE,
  input  logic                PWRITE,
  input  logic [15:0]         PADDR,
  input  logic [WordBits-1:0] PWDATA,
  output logic [WordBits-1:0] PRDATA,
  output logic                PREADY,
  output logic                PSLVERR
);

  localparam int CmdLowBits = $bits(wayCmd_t) - 2; // Fields below flushWay

  wayCmd_t              cmd, cmdA, cmdB;
  logic [IndexBits-1:0] setIndex;
  logic [TagBits-1:0]   lookupTag;
  logic [LineBits-1:0]  writeLine, lineA, lineB, line;
  logic                 cacheEn, anyHit, victimDirty, touch;
  logic [TagBits-1:0]   victimTag;
  logic [1:0]           victimSel;
  wayStatus_t           statusA, statusB;
  memReq_t              memReq;
  memRsp_t              memRsp;

  // Victim bit from the combiner, flush way index decoded one-hot
  assign cmdA = {victimSel[0], ~cmd.flushWay, cmd[CmdLowBits-1:0]};
  assign cmdB = {victimSel[1], cmd.flushWay, cmd[CmdLowBits-1:0]};

  cacheCtrl #(.NumSets(NumSets)) i_ctrl (
    .clk, .reset, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PREADY, .PSLVERR,
    .cmd, .setIndex, .lookupTag, .writeLine, .cacheEn, .anyHit, .line, .victimDirty,
    .victimTag, .touch, .memReq, .memRsp
  );

  cacheWay #(.NumSets(NumSets)) wayA (
    .clk, .reset, .cacheEn, .setIndex, .lookupTag, .cmd(cmdA), .writeLine,
    .readLine(lineA), .status(statusA)
  );

  cacheWay #(.NumSets(NumSets)) wayB (
    .clk, .reset, .cacheEn, .setIndex, .lookupTag, .cmd(cmdB), .writeLine,
    .readLine(lineB), .status(statusB)
  );

  wayCombine #(.NumSets(NumSets)) i_combine (
    .clk, .reset, .setIndex, .statusA, .statusB, .lineA, .lineB, .touch,
    .anyHit, .line, .victimDirty, .victimTag, .victimSel
  );

  backingMem i_mem (
    .clk, .reset, .req(memReq), .rsp(memRsp)
  );

endmodule

`default_nettype wire

/* verif/cacheChecker.sv */
// Expects one queued entry per APB transfer, pushed by the testbench before the transfer starts
`timescale 1ns/1ps
`default_nettype none

module cacheChecker import cachePkg::*; (
  input wire logic                clk,
  input wire logic                PSEL,
  input wire logic                PENABLE,
  input wire logic [15:0]         PADDR,
  input wire logic [WordBits-1:0] PRDATA,
  input wire logic                PREADY,
  input wire logic                PSLVERR
);

  // One expected response
  typedef struct packed {
    logic                checkData;   // Compare PRDATA on reads
    logic                expErr;      // Expected PSLVERR
    logic [WordBits-1:0] expData;
  } expResp_t;

  expResp_t expQ[$];
  expResp_t cur;
  int       mismatches  = 0;
  int       otherErrors = 0;
  int       checked     = 0;

  ////////////////////////////////////////
  // Calls from the testbench
  ////////////////////////////////////////
  task automatic expectResp(input logic checkData, input logic expErr,
                            input logic [WordBits-1:0] expData);
    expQ.push_back({checkData, expErr, expData});
  endtask

  task automatic noteError(input string msg);
    $display("Error: %s", msg);
    otherErrors++;
  endtask

  // Prints the closing counts and returns the total
  task automatic report(output int total);
    if (expQ.size() != 0) begin
      noteError($sformatf("%0d expected responses never arrived", expQ.size()));
    end
    total = mismatches + otherErrors;
    $display("Checker: %0d responses, %0d mismatches, %0d other errors",
             checked, mismatches, otherErrors);
  endtask

  ////////////////////////////////////////
  // Compare at mid-cycle, where PREADY is stable
  ////////////////////////////////////////
  always @(negedge clk) begin
    if (PSEL && PENABLE && PREADY) begin  // Last cycle of a transfer
      if (expQ.size() == 0) begin
        noteError($sformatf("APB response at PADDR %h with nothing expected", PADDR));
      end else begin
        cur = expQ.pop_front();
        checked++;
        if (PSLVERR !== cur.expErr) begin
          $display("Mismatch PSLVERR at PADDR %h: expected %h, got %h",
                   PADDR, cur.expErr, PSLVERR);
          mismatches++;
        end
        if (cur.checkData && PRDATA !== cur.expData) begin
          $display("Mismatch PRDATA at PADDR %h: expected %h, got %h",
                   PADDR, cur.expData, PRDATA);
          mismatches++;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verif/cacheTb.sv */
// Runs apbCache with 16 sets and reads only words it has written, as backing memory has no reset
`timescale 1ns/1ps
`default_nettype none

module cacheTb import cachePkg::*; ();

  localparam int NumSets       = 16;
  localparam int TimeoutCycles = 2000;    // Covers a full flush of dirty lines

  logic                clk;
  logic                reset;
  logic                PSEL;
  logic                PENABLE;
  logic                PWRITE;
  logic [15:0]         PADDR;
  logic [WordBits-1:0] PWDATA;
  logic [WordBits-1:0] PRDATA;
  logic                PREADY;
  logic                PSLVERR;
  integer              seed;

  // Reference model state
  logic [WordBits-1:0] modelMem [1 << MemWordAddrBits];
  int                  modelTag [NumSets][2];
  bit                  modelValid [NumSets][2];
  bit                  modelLru [NumSets];    // Index of the least recent way
  int                  modelHits   = 0;
  int                  modelMisses = 0;
  bit                  written [1 << MemWordAddrBits];
  int                  writtenList[$];

  always #50 clk = ~clk;                      // 100 ns period

  apbCache #(.NumSets(NumSets)) i_dut (
    .clk, .reset, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PREADY, .PSLVERR
  );

  cacheChecker i_check (
    .clk, .PSEL, .PENABLE, .PADDR, .PRDATA, .PREADY, .PSLVERR
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  // One cache-window access that returns the word after the access
  function automatic logic [WordBits-1:0] refModel(input bit isWrite, input int wordAddr,
                                                    input logic [WordBits-1:0] wdata);
    int setIdx;
    int tag;
    int way;
    setIdx = (wordAddr / LineWords) % NumSets;
    tag    = (wordAddr / LineWords) / NumSets;
    way    = -1;
    for (int k = 0; k < 2; k++) begin
      if (modelValid[setIdx][k] && modelTag[setIdx][k] == tag) way = k;
    end
    if (way >= 0) begin
      modelHits++;
    end else begin
      modelMisses++;
      if (!modelValid[setIdx][0]) way = 0;    // Invalid way first
      else if (!modelValid[setIdx][1]) way = 1;
      else way = modelLru[setIdx];
      modelValid[setIdx][way] = 1'b1;
      modelTag[setIdx][way]   = tag;
    end
    modelLru[setIdx] = (way == 0);            // The other way becomes LRU
    if (isWrite) modelMem[wordAddr] = wdata;
    return modelMem[wordAddr];
  endfunction

  function automatic void invalidateModel();
    for (int s = 0; s < NumSets; s++) begin
      modelValid[s][0] = 1'b0;
      modelValid[s][1] = 1'b0;
    end
  endfunction

  function automatic logic [15:0] wordToPaddr(input int wordAddr);
    return 16'(wordAddr << 2);
  endfunction

  function automatic logic [15:0] ctrlPaddr(input int offset);
    return 16'((1 << CtrlWindowBit) | offset);
  endfunction

  ////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////
  task automatic apbTransfer(input bit write, input logic [15:0] addr,
                             input logic [WordBits-1:0] wdata);
    int cycles;
    @(posedge clk);
    #1;
    PSEL    = 1'b1;                           // Setup phase
    PENABLE = 1'b0;
    PWRITE  = write;
    PADDR   = addr;
    PWDATA  = wdata;
    @(posedge clk);
    #1;
    PENABLE = 1'b1;
    cycles  = 0;
    @(negedge clk);
    while (!PREADY && cycles < TimeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!PREADY) begin
      i_check.noteError($sformatf("No PREADY within %0d cycles at PADDR %h",
                                  TimeoutCycles, addr));
    end
    @(posedge clk);
    #1;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic cacheWrite(input int wordAddr, input logic [WordBits-1:0] data);
    void'(refModel(1'b1, wordAddr, data));
    if (!written[wordAddr]) begin
      written[wordAddr] = 1'b1;
      writtenList.push_back(wordAddr);
    end
    i_check.expectResp(1'b0, 1'b0, '0);
    apbTransfer(1'b1, wordToPaddr(wordAddr), data);
  endtask

  task automatic cacheRead(input int wordAddr);
    i_check.expectResp(1'b1, 1'b0, refModel(1'b0, wordAddr, '0));
    apbTransfer(1'b0, wordToPaddr(wordAddr), '0);
  endtask

  task automatic ctrlRead(input int offset, input bit expErr, input logic [WordBits-1:0] data);
    i_check.expectResp(!expErr, expErr, data);
    apbTransfer(1'b0, ctrlPaddr(offset), '0);
  endtask

  task automatic ctrlWrite(input int offset, input logic [WordBits-1:0] data, input bit expErr);
    i_check.expectResp(1'b0, expErr, '0);
    apbTransfer(1'b1, ctrlPaddr(offset), data);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin : stimulus
    int addr;
    int total;
    seed    = 32'hc4e8_d157;
    clk     = 1'b0;
    reset   = 1'b1;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // Random writes, then every written word read back
    for (int i = 0; i < 24; i++) begin
      addr = $random(seed) & 32'h3ff;
      cacheWrite(addr, $random(seed));
    end
    foreach (writtenList[i]) cacheRead(writtenList[i]);

    // Five tags in set 5 push dirty victims out and back in
    for (int t = 0; t < 5; t++) cacheWrite((t + 8) * 64 + 5 * LineWords + t % 4, $random(seed));
    for (int t = 0; t < 5; t++) cacheRead((t + 8) * 64 + 5 * LineWords + t % 4);

    // Mixed traffic in a 256-word region, then the counters
    for (int i = 0; i < 80; i++) begin
      addr = $random(seed) & 32'h0ff;
      if (written[addr] && ($random(seed) & 1)) cacheRead(addr);
      else cacheWrite(addr, $random(seed));
    end
    ctrlRead(0, 1'b0, modelHits);
    ctrlRead(4, 1'b0, modelMisses);

    // Flush, then every word again with first accesses as misses
    ctrlWrite(8, 32'h1, 1'b0);
    invalidateModel();
    foreach (writtenList[i]) cacheRead(writtenList[i]);
    ctrlRead(0, 1'b0, modelHits);
    ctrlRead(4, 1'b0, modelMisses);

    // Illegal control accesses leave the counters alone
    ctrlWrite(0, 32'h5, 1'b1);
    ctrlWrite(4, 32'h5, 1'b1);
    ctrlRead(8, 1'b1, '0);
    ctrlRead(12, 1'b1, '0);
    ctrlWrite(16, 32'h1, 1'b1);
    ctrlRead(0, 1'b0, modelHits);
    ctrlRead(4, 1'b0, modelMisses);

    i_check.report(total);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
rtl/cachePkg.sv
rtl/cacheWay.sv
rtl/wayCombine.sv
rtl/cacheCtrl.sv
rtl/backingMem.sv
rtl/apbCache.sv
verif/cacheChecker.sv
verif/cacheTb.sv

/* Bender.yml */
package:
  name: apb_cache

sources:
  - rtl/cachePkg.sv
  - rtl/cacheWay.sv
  - rtl/wayCombine.sv
  - rtl/cacheCtrl.sv
  - rtl/backingMem.sv
  - rtl/apbCache.sv
  - target: test
    files:
      - verif/cacheChecker.sv
      - verif/cacheTb.sv
